// ==== design/huffman_pkg.sv ====
package huffman_pkg;

    // ####################
    // Alphabet and widths
    // ####################

    // Grey levels 1 to 6 are coded, everything else is dropped
    localparam int NUM_SYMBOLS = 6;

    // Counts and tree weights share one width
    localparam int COUNT_W = 8;

    // Code words and their masks
    localparam int CODE_W = 8;

    // Code length per symbol, at most 5 for six symbols
    localparam int LEN_W = 3;

    // ####################
    // Types
    // ####################

    // Leaves are groups 0 to 5, merged groups count up from 6
    typedef logic [3:0] group_id_t;

    typedef enum logic [2:0]
    {
        IDLE,
        LOAD,
        FIND,
        MERGE,
        REGROUP,
        DONE
    } enc_state_t;

endpackage

// ==== design/symbol_counter.sv ====
`timescale 1ns/100ps

module symbol_counter
    import huffman_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         gray_data,
    input  logic               gray_valid,
    output logic [COUNT_W-1:0] cnt1,
    output logic [COUNT_W-1:0] cnt2,
    output logic [COUNT_W-1:0] cnt3,
    output logic [COUNT_W-1:0] cnt4,
    output logic [COUNT_W-1:0] cnt5,
    output logic [COUNT_W-1:0] cnt6,
    output logic               cnt_valid
);

    logic               gray_valid_d;
    logic               run_start;
    logic               run_end;
    logic [COUNT_W-1:0] cnt [NUM_SYMBOLS];

    // Run edges from the previous valid
    assign run_start = gray_valid && !gray_valid_d;
    assign run_end   = !gray_valid && gray_valid_d;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            gray_valid_d <= 1'b0;
            cnt_valid    <= 1'b0;
            for (int k = 0; k < NUM_SYMBOLS; k++)
                cnt[k] <= '0;
        end
        else
        begin
            gray_valid_d <= gray_valid;
            cnt_valid    <= run_end;
            // Samples outside 1..6 match no slot and leave the counts alone
            if (gray_valid)
            begin
                for (int k = 0; k < NUM_SYMBOLS; k++)
                begin
                    if (run_start)
                        cnt[k] <= (gray_data == 8'(k + 1)) ? COUNT_W'(1) : '0;
                    else if (gray_data == 8'(k + 1))
                        cnt[k] <= cnt[k] + 1'b1;
                end
            end
        end
    end

    assign cnt1 = cnt[0];
    assign cnt2 = cnt[1];
    assign cnt3 = cnt[2];
    assign cnt4 = cnt[3];
    assign cnt5 = cnt[4];
    assign cnt6 = cnt[5];

    // ####################
    // Checks
    // ####################

    a_cnt_valid_pulse: assert property (
        @(posedge clk) disable iff (reset)
        cnt_valid |=> !cnt_valid
    );

endmodule

// ==== design/min_pair_finder.sv ====
`timescale 1ns/100ps

module min_pair_finder
    import huffman_pkg::*;
#(
    parameter int SCAN_START_DELAY = 0
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic [COUNT_W-1:0] weight [NUM_SYMBOLS],
    input  group_id_t          group [NUM_SYMBOLS],
    output logic [2:0]         first_idx,
    output logic [2:0]         second_idx,
    output logic               done
);

    localparam int         DLY_W    = $clog2(SCAN_START_DELAY + 2);
    localparam logic [2:0] LAST_IDX = 3'(NUM_SYMBOLS - 1);

    logic             waiting;
    logic [DLY_W-1:0] wait_cnt;
    logic             active;
    logic             pass2;
    logic [2:0]       ptr;
    logic             have_sec;
    logic             launch;
    logic             step;
    logic [2:0]       idx;
    logic             in_pass2;
    logic             take;

    // Lighter wins, equal weights go to the larger group id
    function automatic logic better(
        input logic [COUNT_W-1:0] w_new,
        input group_id_t          g_new,
        input logic [COUNT_W-1:0] w_old,
        input group_id_t          g_old
    );
        return (w_new < w_old) || ((w_new == w_old) && (g_new > g_old));
    endfunction

    // Without a delay entry 0 is compared on the start edge itself
    assign launch = (SCAN_START_DELAY == 0) ? start
                                            : (waiting && wait_cnt == DLY_W'(1));
    assign step   = launch || active;

    always_comb
    begin
        idx      = launch ? 3'd0 : ptr;
        in_pass2 = !launch && pass2;
        if (!in_pass2)
            take = (idx == 3'd0)
                || better(weight[idx], group[idx], weight[first_idx], group[first_idx]);
        else
            take = (group[idx] != group[first_idx])
                && (!have_sec
                    || better(weight[idx], group[idx], weight[second_idx], group[second_idx]));
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            waiting    <= 1'b0;
            wait_cnt   <= '0;
            active     <= 1'b0;
            pass2      <= 1'b0;
            ptr        <= '0;
            have_sec   <= 1'b0;
            first_idx  <= '0;
            second_idx <= '0;
            done       <= 1'b0;
        end
        else
        begin
            done <= 1'b0;

            if (start && SCAN_START_DELAY != 0)
            begin
                waiting  <= 1'b1;
                wait_cnt <= DLY_W'(SCAN_START_DELAY);
            end
            else if (waiting)
            begin
                wait_cnt <= wait_cnt - 1'b1;
                if (launch)
                    waiting <= 1'b0;
            end

            // One entry per cycle, two passes of six
            if (step)
            begin
                if (take)
                begin
                    if (in_pass2)
                    begin
                        second_idx <= idx;
                        have_sec   <= 1'b1;
                    end
                    else
                        first_idx <= idx;
                end

                if (idx == LAST_IDX)
                begin
                    ptr <= '0;
                    if (in_pass2)
                    begin
                        active <= 1'b0;
                        done   <= 1'b1;
                    end
                    else
                    begin
                        pass2    <= 1'b1;
                        have_sec <= 1'b0;
                    end
                end
                else
                begin
                    ptr    <= idx + 3'd1;
                    active <= 1'b1;
                    if (launch)
                        pass2 <= 1'b0;
                end
            end
        end
    end

    // Groups are held by the encoder for the whole scan
    a_picks_distinct: assert property (
        @(posedge clk) disable iff (reset)
        done |-> group[first_idx] != group[second_idx]
    );

endmodule

// ==== design/huffman_encoder.sv ====
`timescale 1ns/100ps

module huffman_encoder
    import huffman_pkg::*;
#(
    parameter int SCAN_START_DELAY = 0
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic [COUNT_W-1:0] cnt1,
    input  logic [COUNT_W-1:0] cnt2,
    input  logic [COUNT_W-1:0] cnt3,
    input  logic [COUNT_W-1:0] cnt4,
    input  logic [COUNT_W-1:0] cnt5,
    input  logic [COUNT_W-1:0] cnt6,
    input  logic               cnt_valid,
    output logic [CODE_W-1:0]  hc1,
    output logic [CODE_W-1:0]  hc2,
    output logic [CODE_W-1:0]  hc3,
    output logic [CODE_W-1:0]  hc4,
    output logic [CODE_W-1:0]  hc5,
    output logic [CODE_W-1:0]  hc6,
    output logic [CODE_W-1:0]  m1,
    output logic [CODE_W-1:0]  m2,
    output logic [CODE_W-1:0]  m3,
    output logic [CODE_W-1:0]  m4,
    output logic [CODE_W-1:0]  m5,
    output logic [CODE_W-1:0]  m6,
    output logic               code_valid
);

    localparam logic [2:0] LAST_ROUND = 3'(NUM_SYMBOLS - 2);

    enc_state_t         state;
    logic [2:0]         round;
    group_id_t          next_group;
    logic               scan_start;
    logic [2:0]         first_idx;
    logic [2:0]         second_idx;
    logic               scan_done;
    logic [COUNT_W-1:0] cnt_in [NUM_SYMBOLS];
    logic [COUNT_W-1:0] weight [NUM_SYMBOLS];
    group_id_t          group  [NUM_SYMBOLS];
    logic [CODE_W-1:0]  code   [NUM_SYMBOLS];
    logic [LEN_W-1:0]   len    [NUM_SYMBOLS];
    logic [CODE_W-1:0]  mask   [NUM_SYMBOLS];

    assign cnt_in = '{cnt1, cnt2, cnt3, cnt4, cnt5, cnt6};

    min_pair_finder #(
        .SCAN_START_DELAY (SCAN_START_DELAY)
    ) u_finder (
        .clk        (clk),
        .reset      (reset),
        .start      (scan_start),
        .weight     (weight),
        .group      (group),
        .first_idx  (first_idx),
        .second_idx (second_idx),
        .done       (scan_done)
    );

    // ####################
    // Controller
    // ####################

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= IDLE;
            round      <= '0;
            next_group <= '0;
            scan_start <= 1'b0;
            for (int k = 0; k < NUM_SYMBOLS; k++)
            begin
                code[k] <= '0;
                len[k]  <= '0;
            end
        end
        else
        begin
            scan_start <= 1'b0;
            case (state)
                IDLE, DONE:
                begin
                    state <= cnt_valid ? LOAD : IDLE;
                end
                LOAD:
                begin
                    round      <= '0;
                    next_group <= group_id_t'(NUM_SYMBOLS);
                    for (int k = 0; k < NUM_SYMBOLS; k++)
                    begin
                        code[k] <= '0;
                        len[k]  <= '0;
                    end
                    scan_start <= 1'b1;
                    state      <= FIND;
                end
                FIND:
                begin
                    if (scan_done)
                        state <= MERGE;
                end
                MERGE:
                begin
                    // First group takes a 1 at its current length, second a 0
                    for (int k = 0; k < NUM_SYMBOLS; k++)
                    begin
                        if (group[k] == group[first_idx])
                        begin
                            code[k][len[k]] <= 1'b1;
                            len[k]          <= len[k] + 1'b1;
                        end
                        else if (group[k] == group[second_idx])
                        begin
                            code[k][len[k]] <= 1'b0;
                            len[k]          <= len[k] + 1'b1;
                        end
                    end
                    state <= REGROUP;
                end
                REGROUP:
                begin
                    next_group <= next_group + 1'b1;
                    round      <= round + 1'b1;
                    if (round == LAST_ROUND)
                        state <= DONE;
                    else
                    begin
                        scan_start <= 1'b1;
                        state      <= FIND;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ####################
    // Tree arrays
    // ####################

    always_ff @(posedge clk)
    begin
        for (int k = 0; k < NUM_SYMBOLS; k++)
        begin
            if (state == LOAD)
            begin
                weight[k] <= cnt_in[k];
                group[k]  <= group_id_t'(k);
            end
            else if (state == MERGE)
            begin
                if (group[k] == group[first_idx] || group[k] == group[second_idx])
                    weight[k] <= weight[first_idx] + weight[second_idx];
            end
            else if (state == REGROUP)
            begin
                if (group[k] == group[first_idx] || group[k] == group[second_idx])
                    group[k] <= next_group;
            end
        end
    end

    // Mask is len low-order ones
    always_comb
    begin
        for (int k = 0; k < NUM_SYMBOLS; k++)
            mask[k] = ~({CODE_W{1'b1}} << len[k]);
    end

    assign code_valid = (state == DONE);

    assign hc1 = code[0];
    assign hc2 = code[1];
    assign hc3 = code[2];
    assign hc4 = code[3];
    assign hc5 = code[4];
    assign hc6 = code[5];

    assign m1 = mask[0];
    assign m2 = mask[1];
    assign m3 = mask[2];
    assign m4 = mask[3];
    assign m5 = mask[4];
    assign m6 = mask[5];

    // New counts only while no tree is being built
    a_no_overrun: assert property (
        @(posedge clk) disable iff (reset)
        cnt_valid |-> (state == IDLE || state == DONE)
    );

endmodule

// ==== design/huffman_top.sv ====
`timescale 1ns/100ps

module huffman_top
    import huffman_pkg::*;
#(
    parameter int SCAN_START_DELAY = 0
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         gray_data,
    input  logic               gray_valid,
    output logic [COUNT_W-1:0] cnt1,
    output logic [COUNT_W-1:0] cnt2,
    output logic [COUNT_W-1:0] cnt3,
    output logic [COUNT_W-1:0] cnt4,
    output logic [COUNT_W-1:0] cnt5,
    output logic [COUNT_W-1:0] cnt6,
    output logic               cnt_valid,
    output logic [CODE_W-1:0]  hc1,
    output logic [CODE_W-1:0]  hc2,
    output logic [CODE_W-1:0]  hc3,
    output logic [CODE_W-1:0]  hc4,
    output logic [CODE_W-1:0]  hc5,
    output logic [CODE_W-1:0]  hc6,
    output logic [CODE_W-1:0]  m1,
    output logic [CODE_W-1:0]  m2,
    output logic [CODE_W-1:0]  m3,
    output logic [CODE_W-1:0]  m4,
    output logic [CODE_W-1:0]  m5,
    output logic [CODE_W-1:0]  m6,
    output logic               code_valid
);

    symbol_counter u_counter (
        .clk        (clk),
        .reset      (reset),
        .gray_data  (gray_data),
        .gray_valid (gray_valid),
        .cnt1       (cnt1),
        .cnt2       (cnt2),
        .cnt3       (cnt3),
        .cnt4       (cnt4),
        .cnt5       (cnt5),
        .cnt6       (cnt6),
        .cnt_valid  (cnt_valid)
    );

    // Counts feed the outside and the encoder alike
    huffman_encoder #(
        .SCAN_START_DELAY (SCAN_START_DELAY)
    ) u_encoder (
        .clk        (clk),
        .reset      (reset),
        .cnt1       (cnt1),
        .cnt2       (cnt2),
        .cnt3       (cnt3),
        .cnt4       (cnt4),
        .cnt5       (cnt5),
        .cnt6       (cnt6),
        .cnt_valid  (cnt_valid),
        .hc1        (hc1),
        .hc2        (hc2),
        .hc3        (hc3),
        .hc4        (hc4),
        .hc5        (hc5),
        .hc6        (hc6),
        .m1         (m1),
        .m2         (m2),
        .m3         (m3),
        .m4         (m4),
        .m5         (m5),
        .m6         (m6),
        .code_valid (code_valid)
    );

endmodule

// ==== sim/huffman_ref_model.svh ====
`ifndef HUFFMAN_REF_MODEL_SVH
`define HUFFMAN_REF_MODEL_SVH

// Samples of one stream
logic [7:0]         stim [0:255];
int                 stim_len;

// Results expected for the stream in stim
logic [COUNT_W-1:0] exp_cnt  [NUM_SYMBOLS];
logic [CODE_W-1:0]  exp_code [NUM_SYMBOLS];
logic [CODE_W-1:0]  exp_mask [NUM_SYMBOLS];
int                 exp_len  [NUM_SYMBOLS];

// Tree state of the model, one entry per symbol
int                 mdl_weight [NUM_SYMBOLS];
int                 mdl_group  [NUM_SYMBOLS];

// Lightest live group apart from skip_group, equal weights go to the larger id
function automatic int lightest_group(input int skip_group);
    int best_g;
    int best_w;
    best_g = -1;
    best_w = 0;
    for (int k = 0; k < NUM_SYMBOLS; k++)
    begin
        if (mdl_group[k] != skip_group)
        begin
            if (best_g < 0 || mdl_weight[k] < best_w
                || (mdl_weight[k] == best_w && mdl_group[k] > best_g))
            begin
                best_g = mdl_group[k];
                best_w = mdl_weight[k];
            end
        end
    end
    return best_g;
endfunction

function automatic int group_weight(input int g);
    for (int k = 0; k < NUM_SYMBOLS; k++)
        if (mdl_group[k] == g)
            return mdl_weight[k];
    return 0;
endfunction

task automatic build_expected();
    int sym;
    int first_g;
    int second_g;
    int merged_w;
    begin
        for (int k = 0; k < NUM_SYMBOLS; k++)
            exp_cnt[k] = '0;
        // Only grey levels 1 to 6 are counted
        for (int i = 0; i < stim_len; i++)
        begin
            sym = stim[i];
            if (sym >= 1 && sym <= NUM_SYMBOLS)
                exp_cnt[sym-1] = exp_cnt[sym-1] + 1'b1;
        end
        for (int k = 0; k < NUM_SYMBOLS; k++)
        begin
            mdl_weight[k] = exp_cnt[k];
            mdl_group[k]  = k;
            exp_code[k]   = '0;
            exp_len[k]    = 0;
        end
        // Five merges, new groups numbered from 6 upward
        for (int r = 0; r < NUM_SYMBOLS - 1; r++)
        begin
            first_g  = lightest_group(-1);
            second_g = lightest_group(first_g);
            merged_w = group_weight(first_g) + group_weight(second_g);
            for (int k = 0; k < NUM_SYMBOLS; k++)
            begin
                if (mdl_group[k] == first_g || mdl_group[k] == second_g)
                begin
                    exp_code[k][exp_len[k]] = (mdl_group[k] == first_g);
                    exp_len[k]    = exp_len[k] + 1;
                    mdl_weight[k] = merged_w;
                    mdl_group[k]  = NUM_SYMBOLS + r;
                end
            end
        end
        for (int k = 0; k < NUM_SYMBOLS; k++)
        begin
            exp_mask[k] = '0;
            for (int b = 0; b < exp_len[k]; b++)
                exp_mask[k][b] = 1'b1;
        end
    end
endtask

`endif

// ==== sim/tb_huffman.sv ====
`timescale 1ns/100ps

module tb_huffman
    import huffman_pkg::*;
();

    localparam int CLK_PERIOD       = 100;
    localparam int SCAN_START_DELAY = 2;
    localparam int NUM_TESTS        = 6;
    localparam int STREAM_MAX       = 64;
    localparam int WAIT_LIMIT       = 200;
    localparam int WATCHDOG_CYCLES  = NUM_TESTS * (STREAM_MAX + 200);

    logic               clk;
    logic               reset;
    logic [7:0]         gray_data;
    logic               gray_valid;
    logic [COUNT_W-1:0] cnt [NUM_SYMBOLS];
    logic               cnt_valid;
    logic [CODE_W-1:0]  hc  [NUM_SYMBOLS];
    logic [CODE_W-1:0]  m   [NUM_SYMBOLS];
    logic               code_valid;
    integer             seed;
    int                 value_errors;
    int                 other_errors;

    `include "huffman_ref_model.svh"

    huffman_top #(
        .SCAN_START_DELAY (SCAN_START_DELAY)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .gray_data  (gray_data),
        .gray_valid (gray_valid),
        .cnt1       (cnt[0]),
        .cnt2       (cnt[1]),
        .cnt3       (cnt[2]),
        .cnt4       (cnt[3]),
        .cnt5       (cnt[4]),
        .cnt6       (cnt[5]),
        .cnt_valid  (cnt_valid),
        .hc1        (hc[0]),
        .hc2        (hc[1]),
        .hc3        (hc[2]),
        .hc4        (hc[3]),
        .hc5        (hc[4]),
        .hc6        (hc[5]),
        .m1         (m[0]),
        .m2         (m[1]),
        .m3         (m[2]),
        .m4         (m[3]),
        .m5         (m[4]),
        .m6         (m[5]),
        .code_valid (code_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ####################
    // Compare tasks
    // ####################

    task automatic compare_count(input string name, input logic [COUNT_W-1:0] expected,
                                 input logic [COUNT_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic compare_code(input string name, input logic [CODE_W-1:0] expected,
                                input logic [CODE_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic verify_counts();
        for (int k = 0; k < NUM_SYMBOLS; k++)
            compare_count($sformatf("cnt%0d", k + 1), exp_cnt[k], cnt[k]);
    endtask

    task automatic verify_codes();
        for (int k = 0; k < NUM_SYMBOLS; k++)
        begin
            compare_code($sformatf("hc%0d", k + 1), exp_code[k], hc[k]);
            compare_code($sformatf("m%0d", k + 1), exp_mask[k], m[k]);
        end
    endtask

    function automatic int count_ones(input logic [CODE_W-1:0] word);
        int n;
        n = 0;
        for (int b = 0; b < CODE_W; b++)
            n += (word[b] === 1'b1);
        return n;
    endfunction

    // ####################
    // Stimulus helpers
    // ####################

    task automatic add_samples(input logic [7:0] value, input int n);
        for (int i = 0; i < n; i++)
        begin
            stim[stim_len] = value;
            stim_len++;
        end
    endtask

    // Values 0 and 7 come out too and must be ignored
    task automatic add_random(input int n);
        logic [31:0] rnd;
        for (int i = 0; i < n; i++)
        begin
            rnd            = $random(seed);
            stim[stim_len] = {5'd0, rnd[2:0]};
            stim_len++;
        end
    endtask

    task automatic drive_stream();
        for (int i = 0; i < stim_len; i++)
        begin
            @(posedge clk);
            gray_data  <= stim[i];
            gray_valid <= 1'b1;
        end
        @(posedge clk);
        gray_valid <= 1'b0;
        gray_data  <= '0;
    endtask

    task automatic wait_valid(input bit for_code, output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            seen = for_code ? (code_valid === 1'b1) : (cnt_valid === 1'b1);
            n++;
        end
        if (!seen)
        begin
            $display("Timeout at %0t: %s did not arrive within %0d cycles", $time,
                     for_code ? "code_valid" : "cnt_valid", WAIT_LIMIT);
            other_errors++;
        end
    endtask

    // Old codes must still stand when the new counts arrive
    task automatic run_and_check(input bit held_check);
        bit seen;
        drive_stream();
        wait_valid(1'b0, seen);
        if (held_check)
            verify_codes();
        build_expected();
        if (seen)
            verify_counts();
        wait_valid(1'b1, seen);
        if (seen)
            verify_codes();
    endtask

    // ####################
    // Directed tests
    // ####################

    task automatic counting_test();
        bit seen;
        stim_len = 0;
        add_samples(8'd5, 3);
        add_samples(8'd0, 2);
        add_samples(8'd2, 1);
        add_samples(8'd7, 2);
        add_samples(8'd4, 2);
        add_samples(8'd1, 4);
        add_samples(8'd6, 1);
        add_samples(8'd200, 1);
        add_samples(8'd5, 1);
        build_expected();
        drive_stream();
        @(negedge clk);
        if (cnt_valid !== 1'b0)
        begin
            $display("At %0t cnt_valid rose before the end of the stream was seen", $time);
            other_errors++;
        end
        @(negedge clk);
        if (cnt_valid !== 1'b1)
        begin
            $display("At %0t cnt_valid did not come one cycle after the stream", $time);
            other_errors++;
        end
        else
            verify_counts();
        @(negedge clk);
        if (cnt_valid !== 1'b0)
        begin
            $display("At %0t cnt_valid stayed high for more than one cycle", $time);
            other_errors++;
        end
        wait_valid(1'b1, seen);
        if (seen)
            verify_codes();
    endtask

    task automatic distinct_weights_test();
        stim_len = 0;
        add_samples(8'd1, 2);
        add_samples(8'd2, 3);
        add_samples(8'd3, 5);
        add_samples(8'd4, 7);
        add_samples(8'd5, 11);
        add_samples(8'd6, 13);
        run_and_check(1'b1);
        for (int k = 0; k < NUM_SYMBOLS; k++)
            compare_count($sformatf("ones of m%0d", k + 1), COUNT_W'(exp_len[k]),
                          COUNT_W'(count_ones(m[k])));
    endtask

    task automatic tie_test();
        stim_len = 0;
        for (int k = 1; k <= NUM_SYMBOLS; k++)
            add_samples(8'(k), 4);
        run_and_check(1'b1);
    endtask

    task automatic zero_count_test();
        stim_len = 0;
        add_samples(8'd2, 5);
        add_samples(8'd4, 2);
        add_samples(8'd6, 9);
        run_and_check(1'b1);
    endtask

    task automatic back_to_back_test();
        stim_len = 0;
        add_random(48);
        run_and_check(1'b1);
        stim_len = 0;
        add_random(60);
        run_and_check(1'b1);
    endtask

    task automatic reset_test();
        bit seen;
        stim_len = 0;
        add_random(30);
        drive_stream();
        wait_valid(1'b0, seen);
        // Reset has to land while the tree is still being built
        repeat (20)
        begin
            @(negedge clk);
            if (code_valid !== 1'b0)
            begin
                $display("At %0t encoding ended before reset could hit it", $time);
                other_errors++;
            end
        end
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        for (int k = 0; k < NUM_SYMBOLS; k++)
        begin
            compare_count($sformatf("cnt%0d", k + 1), '0, cnt[k]);
            compare_code($sformatf("hc%0d", k + 1), '0, hc[k]);
            compare_code($sformatf("m%0d", k + 1), '0, m[k]);
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // The interrupted tree must never complete
        repeat (WAIT_LIMIT)
        begin
            @(negedge clk);
            if (cnt_valid !== 1'b0 || code_valid !== 1'b0)
            begin
                $display("At %0t a valid strobe was high after reset", $time);
                other_errors++;
            end
        end
        stim_len = 0;
        add_random(20);
        run_and_check(1'b0);
    endtask

    // ####################
    // Main sequence
    // ####################

    initial
    begin
        seed         = 32'hc4f9;
        value_errors = 0;
        other_errors = 0;
        stim_len     = 0;
        reset        = 1'b1;
        gray_data    = '0;
        gray_valid   = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        counting_test();
        distinct_weights_test();
        tie_test();
        zero_count_test();
        back_to_back_test();
        reset_test();
        $display("Summary: %0d value errors, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+sim
design/huffman_pkg.sv
design/symbol_counter.sv
design/min_pair_finder.sv
design/huffman_encoder.sv
design/huffman_top.sv
sim/tb_huffman.sv
